// File: Makefile
VERILATOR ?= verilator
TOP       ?= boardDisplayTb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q -F -x -- "** PASS **" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: list.f
verilog/boardPkg.sv
verilog/scanTiming.sv
verilog/cursorControl.sv
verilog/modSquareGen.sv
verilog/pixelColorMux.sv
verilog/boardDisplayTop.sv
tb/clockGen.sv
tb/boardChecker.sv
tb/boardDisplay_props.sv
tb/boardDisplayTb.sv

// File: tb/boardChecker.sv
// --------------------------------------------------
// board display checker
// keeps its own cursor model from the strobes and
// its own raster position, and compares every output
// pixel's position, flags and color plus sync spacing
// --------------------------------------------------
`timescale 1ns/1ps

module boardChecker #(
    parameter int hTotal = 400,
    parameter int vTotal = 262
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             moveCol,
    input  logic             moveRow,
    input  logic             select,
    input  boardPkg::cursorT expCursor,
    input  boardPkg::pixelT  pixelOut,
    output int               colorErrors,
    output int               syncErrors,
    output int               cursorErrors
);
    import boardPkg::*;

    localparam int printLimit = 20;

    cursorT     model;
    logic       pendCol;
    logic       pendRow;
    logic       pendSel;
    logic       armed;
    logic       lineSeen;
    logic       wasReset;
    longint     cycle;
    longint     lastHsync;
    longint     lastVsync;
    longint     firstVsync;
    longint     pos;
    int         px;
    int         py;
    logic [2:0] expFlags;
    rgb12       expColor;
    // name of the command being applied, written by the testbench
    string      pendingName;
    string      frameName;

    // square index along one axis, -1 when outside both squares
    function automatic int squareAt(int c);
        int idx;
        idx = -1;
        // index 0 is the square at 130..220, index 1 the one at 20..110
        if (c > 130 && c < 220) begin
            idx = 0;
        end else if (c > 20 && c < 110) begin
            idx = 1;
        end
        return idx;
    endfunction

    // highlight window centered at 175 - 110 * index, half width 55
    function automatic logic inHighlight(int c, logic sel);
        int center;
        center = 175 - 110 * int'(sel);
        return (c > center - 55) && (c < center + 55);
    endfunction

    function automatic rgb12 expectedColor(int x, int y, cursorT cur);
        int         sx;
        int         sy;
        logic [1:0] idx;
        sx = squareAt(x);
        sy = squareAt(y);
        idx = 2'(sy * 2 + sx);
        if (x >= 320 || y >= 240) begin
            return colorBg;
        end
        if (inHighlight(x, cur.col) && inHighlight(y, cur.row)) begin
            return colorHighlight;
        end
        if (sx >= 0 && sy >= 0) begin
            return cur.marks[idx] ? colorMarked : colorSquare;
        end
        return colorBg;
    endfunction

    always @(posedge clk) begin
        if (reset) begin
            model        = '0;
            pendCol      = 1'b0;
            pendRow      = 1'b0;
            pendSel      = 1'b0;
            armed        = 1'b0;
            lineSeen     = 1'b0;
            wasReset     = 1'b1;
            cycle        = 0;
            firstVsync   = 0;
            colorErrors  = 0;
            syncErrors   = 0;
            cursorErrors = 0;
            pendingName  = "reset";
            frameName    = "reset";
        end else begin
            cycle = cycle + 1;
            // first pixel after reset still holds the reset value
            if (wasReset && pixelOut.scan[2:0] !== 3'b000) begin
                syncErrors++;
                $display("pixel stream flags were not low coming out of reset");
            end
            wasReset = 1'b0;
            if (pixelOut.scan.vsync) begin
                if (armed && (cycle - lastVsync) != longint'(hTotal * vTotal)) begin
                    syncErrors++;
                    $display("error %s: vsync spacing expected %0d actual %0d",
                             frameName, hTotal * vTotal, cycle - lastVsync);
                end
                // the raster position is counted from the first frame start
                if (!armed) begin
                    firstVsync = cycle;
                end
                lastVsync = cycle;
                armed     = 1'b1;
                // commit the previous frame's strobes, moves before the mark
                model.col = model.col ^ pendCol;
                model.row = model.row ^ pendRow;
                if (pendSel) begin
                    model.marks[{model.row, model.col}] = ~model.marks[{model.row, model.col}];
                end
                pendCol   = 1'b0;
                pendRow   = 1'b0;
                pendSel   = 1'b0;
                frameName = pendingName;
                if (model !== expCursor) begin
                    cursorErrors++;
                    $display("error %s: cursor expected %h actual %h",
                             frameName, expCursor, model);
                end
            end
            if (pixelOut.scan.hsync) begin
                if (lineSeen && (cycle - lastHsync) != longint'(hTotal)) begin
                    syncErrors++;
                    $display("error %s: hsync spacing expected %0d actual %0d",
                             frameName, hTotal, cycle - lastHsync);
                end
                lastHsync = cycle;
                lineSeen  = 1'b1;
            end
            pendCol = pendCol | moveCol;
            pendRow = pendRow | moveRow;
            pendSel = pendSel | select;
            if (armed) begin
                // expected pixel and line from the cycle count
                pos      = cycle - firstVsync;
                px       = int'(pos % longint'(hTotal));
                py       = int'((pos / longint'(hTotal)) % longint'(vTotal));
                expFlags = {px < 320 && py < 240, px == 0, px == 0 && py == 0};
                expColor = expectedColor(px, py, model);
                if (pixelOut.scan.x !== xCoord'(px) || pixelOut.scan.y !== yCoord'(py)) begin
                    syncErrors++;
                    if (syncErrors <= printLimit) begin
                        $display("error %s: position expected (%0d,%0d) actual (%0d,%0d)",
                                 frameName, px, yCoord'(py),
                                 pixelOut.scan.x, pixelOut.scan.y);
                    end
                end
                if (pixelOut.scan[2:0] !== expFlags) begin
                    syncErrors++;
                    if (syncErrors <= printLimit) begin
                        $display("error %s: flags at (%0d,%0d) expected %b actual %b",
                                 frameName, px, py, expFlags, pixelOut.scan[2:0]);
                    end
                end
                if (pixelOut.color !== expColor) begin
                    colorErrors++;
                    if (colorErrors <= printLimit) begin
                        $display("error %s: color at (%0d,%0d) expected %h actual %h",
                                 frameName, px, py, expColor, pixelOut.color);
                    end
                end
            end
        end
    end

endmodule

// File: tb/boardDisplayTb.sv
// --------------------------------------------------
// board display testbench
// applies a table of button commands, one per frame
// at line 120, with random select commands after the
// fixed ones; the checker judges every pixel
// --------------------------------------------------
`timescale 1ns/1ps

module boardDisplayTb;
    import boardPkg::*;

    localparam int hTotal      = 400;
    localparam int vTotal      = 262;
    localparam int fixedCount  = 12;
    localparam int randomCount = 4;

    // strobes of one command and the cursor once they commit
    typedef struct packed {
        logic   moveCol;
        logic   moveRow;
        logic   select;
        cursorT expCursor;
    } cmdT;

    // expected cursor is {row, col, marks[3:0]}
    localparam cmdT fixedCmds [fixedCount] = '{
        '{1'b0, 1'b0, 1'b0, 6'b00_0000},
        '{1'b1, 1'b0, 1'b0, 6'b01_0000},
        '{1'b1, 1'b0, 1'b0, 6'b00_0000},
        '{1'b0, 1'b1, 1'b0, 6'b10_0000},
        '{1'b0, 1'b1, 1'b0, 6'b00_0000},
        '{1'b1, 1'b1, 1'b0, 6'b11_0000},
        '{1'b0, 1'b0, 1'b1, 6'b11_1000},
        '{1'b1, 1'b0, 1'b0, 6'b10_1000},
        '{1'b1, 1'b0, 1'b0, 6'b11_1000},
        '{1'b0, 1'b0, 1'b1, 6'b11_0000},
        '{1'b1, 1'b0, 1'b1, 6'b10_0100},
        '{1'b0, 1'b0, 1'b0, 6'b10_0100}
    };
    string fixedNames [fixedCount] = '{
        "idle", "col", "col back", "row", "row back", "diagonal",
        "select", "move away", "col return", "unmark", "col and select", "idle end"
    };

    cmdT    cmdQ [$];
    string  nameQ [$];
    cmdT    extra;
    cursorT cur;
    int     seed;
    int     r;
    int     cycleCount;
    int     timeoutLimit;

    logic   clk;
    logic   reset;
    logic   moveCol;
    logic   moveRow;
    logic   select;
    cursorT expCursor;
    pixelT  pixelOut;
    int     colorErrors;
    int     syncErrors;
    int     cursorErrors;

    function automatic cursorT nextCursor(cursorT c, cmdT cmd);
        cursorT     n;
        logic [1:0] idx;
        n     = c;
        n.col = c.col ^ cmd.moveCol;
        n.row = c.row ^ cmd.moveRow;
        idx   = {n.row, n.col};
        if (cmd.select) begin
            n.marks[idx] = ~n.marks[idx];
        end
        return n;
    endfunction

    clockGen #(.period(20), .resetCycles(10)) u_clockGen (
        .clk   (clk),
        .reset (reset)
    );

    boardDisplayTop u_boardDisplayTop (
        .clk      (clk),
        .reset    (reset),
        .moveCol  (moveCol),
        .moveRow  (moveRow),
        .select   (select),
        .pixelOut (pixelOut)
    );

    boardChecker #(.hTotal(hTotal), .vTotal(vTotal)) u_boardChecker (
        .clk          (clk),
        .reset        (reset),
        .moveCol      (moveCol),
        .moveRow      (moveRow),
        .select       (select),
        .expCursor    (expCursor),
        .pixelOut     (pixelOut),
        .colorErrors  (colorErrors),
        .syncErrors   (syncErrors),
        .cursorErrors (cursorErrors)
    );

    // each command takes about one frame, plus reset and the last frame
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutLimit) begin
            $display("timeout after %0d cycles, command loop never finished", cycleCount);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        moveCol    = 1'b0;
        moveRow    = 1'b0;
        select     = 1'b0;
        expCursor  = '0;
        cycleCount = 0;
        seed       = 1367;
        for (int i = 0; i < fixedCount; i++) begin
            cmdQ.push_back(fixedCmds[i]);
            nameQ.push_back(fixedNames[i]);
        end
        // random selects, each maybe with a move
        cur = fixedCmds[fixedCount - 1].expCursor;
        for (int k = 0; k < randomCount; k++) begin
            r             = $random(seed);
            extra.moveCol = r[0];
            extra.moveRow = r[1];
            extra.select  = 1'b1;
            cur           = nextCursor(cur, extra);
            extra.expCursor = cur;
            cmdQ.push_back(extra);
            nameQ.push_back($sformatf("random %0d", k));
        end
        timeoutLimit = (cmdQ.size() + 3) * hTotal * vTotal;

        do @(posedge clk); while (reset !== 1'b0);
        for (int i = 0; i < cmdQ.size(); i++) begin
            do @(posedge clk); while (pixelOut.scan.y != 8'd120);
            moveCol   <= cmdQ[i].moveCol;
            moveRow   <= cmdQ[i].moveRow;
            select    <= cmdQ[i].select;
            expCursor <= cmdQ[i].expCursor;
            u_boardChecker.pendingName = nameQ[i];
            @(posedge clk);
            moveCol <= 1'b0;
            moveRow <= 1'b0;
            select  <= 1'b0;
            // leave line 120 so the next wait spans a whole frame
            do @(posedge clk); while (pixelOut.scan.y == 8'd120);
        end
        // commit of the last command, then its whole frame
        repeat (2) begin
            do @(posedge clk); while (!pixelOut.scan.vsync);
        end
        @(negedge clk);

        $display("errors: color %0d sync %0d cursor %0d", colorErrors, syncErrors, cursorErrors);
        if (colorErrors + syncErrors + cursorErrors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: tb/boardDisplay_props.sv
// --------------------------------------------------
// board display assertions
// commit timing of the cursor FSM and the visible
// area of the scan stream
// --------------------------------------------------
`timescale 1ns/1ps

module boardDisplayProps (
    input logic               clk,
    input logic               reset,
    input boardPkg::scanT     scan,
    input boardPkg::cursorT   cursor,
    input boardPkg::ctrlState state
);
    import boardPkg::*;

    // new cursor shows up two samples after the scan vsync
    cursorOnCommit: assert property (@(posedge clk) disable iff (reset)
        (cursor != $past(cursor)) |-> $past(scan.vsync, 2))
        else $error("cursor changed outside the commit cycle");

    applyOneCycle: assert property (@(posedge clk) disable iff (reset)
        (state == applyCmd) |=> (state == waitFrame))
        else $error("applyCmd held for more than one cycle");

    activeInside: assert property (@(posedge clk) disable iff (reset)
        scan.active |-> (scan.x < 9'd320) && (scan.y < 8'd240))
        else $error("active flag set outside the 320x240 area");

endmodule

bind cursorControl boardDisplayProps u_cursorProps (
    .clk    (clk),
    .reset  (reset),
    .scan   (scan),
    .cursor (cursor),
    .state  (state)
);

// no FSM here, only the area check has anything to look at
bind scanTiming boardDisplayProps u_scanProps (
    .clk    (clk),
    .reset  (reset),
    .scan   (scan),
    .cursor ('0),
    .state  (boardPkg::waitFrame)
);

// File: tb/clockGen.sv
// --------------------------------------------------
// testbench clock and reset
// free running clock, reset held high for a fixed
// number of rising edges after time zero
// --------------------------------------------------
`timescale 1ns/1ps

module clockGen #(
    parameter int period      = 20,
    parameter int resetCycles = 10
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period / 2) clk = ~clk;
        end
    end

    // release lines up with a rising edge
    initial begin
        reset = 1'b1;
        repeat (resetCycles) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// File: verilog/boardDisplayTop.sv
// --------------------------------------------------
// board display top level
// scan timing, cursor control, square generator and
// color select chained into one pixel stream
// --------------------------------------------------
`timescale 1ns/1ps

module boardDisplayTop #(
    parameter int hTotal = 400,
    parameter int vTotal = 262
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           moveCol,
    input  logic           moveRow,
    input  logic           select,
    output boardPkg::pixelT pixelOut
);
    import boardPkg::*;

    scanT       scan;
    scanT       scanDly;
    cursorT     cursor;
    logic       squarePix;
    logic       highlightPix;
    logic [1:0] squareIdx;

    scanTiming #(
        .hTotal (hTotal),
        .vTotal (vTotal)
    ) u_scanTiming (
        .clk   (clk),
        .reset (reset),
        .scan  (scan)
    );

    cursorControl u_cursorControl (
        .clk     (clk),
        .reset   (reset),
        .moveCol (moveCol),
        .moveRow (moveRow),
        .select  (select),
        .scan    (scan),
        .cursor  (cursor)
    );

    modSquareGen u_modSquareGen (
        .clk          (clk),
        .reset        (reset),
        .scan         (scan),
        .cursor       (cursor),
        .scanDly      (scanDly),
        .squarePix    (squarePix),
        .highlightPix (highlightPix),
        .squareIdx    (squareIdx)
    );

    // color stage reads the same cursor, which only changes before any square pixel
    pixelColorMux u_pixelColorMux (
        .clk          (clk),
        .reset        (reset),
        .scanDly      (scanDly),
        .squarePix    (squarePix),
        .highlightPix (highlightPix),
        .squareIdx    (squareIdx),
        .cursor       (cursor),
        .pixelOut     (pixelOut)
    );

endmodule

// File: verilog/boardPkg.sv
// --------------------------------------------------
// board display shared types
// coordinate, color, scan stream and cursor types,
// plus square geometry and palette used by the
// board raster blocks
// --------------------------------------------------
package boardPkg;

    // raster coordinates for the 320x240 area
    typedef logic [8:0] xCoord;
    typedef logic [7:0] yCoord;

    // 4 bits per channel, r in the top nibble
    typedef logic [11:0] rgb12;

    // selection plus one mark bit per square, index is row*2 + col
    typedef struct packed {
        logic       row;
        logic       col;
        logic [3:0] marks;
    } cursorT;

    // one raster position with its flags
    typedef struct packed {
        xCoord x;
        yCoord y;
        logic  active;
        logic  hsync;
        logic  vsync;
    } scanT;

    typedef struct packed {
        scanT scan;
        rgb12 color;
    } pixelT;

    typedef enum logic {
        waitFrame,
        applyCmd
    } ctrlState;

    // squares span strictly between lo and lo + span on each axis
    localparam int squareLo0  = 20;
    localparam int squareLo1  = 130;
    localparam int squareSpan = 90;

    // highlight center is base minus step times the selected index
    localparam int hlCenterBase = 175;
    localparam int hlStep       = 110;
    localparam int hlHalf       = 55;

    localparam rgb12 colorBg        = 12'h000;
    localparam rgb12 colorSquare    = 12'h888;
    localparam rgb12 colorMarked    = 12'h00f;
    localparam rgb12 colorHighlight = 12'hff0;

endpackage

// File: verilog/cursorControl.sv
// --------------------------------------------------
// cursor control FSM
// collects button strobes during a frame and commits
// them once at frame start: column and row moves
// first, then the mark toggle on the new square
// --------------------------------------------------
`timescale 1ns/1ps

module cursorControl (
    input  logic            clk,
    input  logic            reset,
    input  logic            moveCol,
    input  logic            moveRow,
    input  logic            select,
    input  boardPkg::scanT   scan,
    output boardPkg::cursorT cursor
);
    import boardPkg::*;

    ctrlState state;

    // strobes seen since the last commit
    logic pendCol;
    logic pendRow;
    logic pendSel;

    // selection after the pending moves
    logic       newRow;
    logic       newCol;
    logic [1:0] newIdx;

    always_comb begin
        newRow = cursor.row ^ pendRow;
        newCol = cursor.col ^ pendCol;
        newIdx = {newRow, newCol};
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= waitFrame;
            pendCol <= 1'b0;
            pendRow <= 1'b0;
            pendSel <= 1'b0;
            cursor  <= '0;
        end else begin
            case (state)
                waitFrame: begin
                    pendCol <= pendCol | moveCol;
                    pendRow <= pendRow | moveRow;
                    pendSel <= pendSel | select;
                    // frame start, commit on the next cycle
                    if (scan.vsync) begin
                        state <= applyCmd;
                    end
                end
                applyCmd: begin
                    cursor.row <= newRow;
                    cursor.col <= newCol;
                    // the mark goes to the square selected after the moves
                    if (pendSel) begin
                        cursor.marks[newIdx] <= ~cursor.marks[newIdx];
                    end
                    // strobes landing now are held for the next frame
                    pendCol <= moveCol;
                    pendRow <= moveRow;
                    pendSel <= select;
                    state   <= waitFrame;
                end
                default: begin
                    state <= waitFrame;
                end
            endcase
        end
    end

endmodule

// File: verilog/modSquareGen.sv
// --------------------------------------------------
// board square generator
// flags pixels inside the four gray squares and the
// highlight window around the selected square, one
// cycle behind the incoming scan
// --------------------------------------------------
`timescale 1ns/1ps

module modSquareGen (
    input  logic            clk,
    input  logic            reset,
    input  boardPkg::scanT   scan,
    input  boardPkg::cursorT cursor,
    output boardPkg::scanT   scanDly,
    output logic            squarePix,
    output logic            highlightPix,
    output logic [1:0]      squareIdx
);
    import boardPkg::*;

    int   px;
    int   py;
    int   colCenter;
    int   rowCenter;
    logic inX0;
    logic inX1;
    logic inY0;
    logic inY1;
    logic squareHit;
    logic highlightHit;

    always_comb begin
        px = int'(scan.x);
        py = int'(scan.y);
        // square windows, open on both ends
        inX0 = (px > squareLo0) && (px < squareLo0 + squareSpan);
        inX1 = (px > squareLo1) && (px < squareLo1 + squareSpan);
        inY0 = (py > squareLo0) && (py < squareLo0 + squareSpan);
        inY1 = (py > squareLo1) && (py < squareLo1 + squareSpan);
        squareHit = (inX0 || inX1) && (inY0 || inY1);
        // index 0 sits at the far square, so the low window is index 1
        colCenter = hlCenterBase - hlStep * int'(cursor.col);
        rowCenter = hlCenterBase - hlStep * int'(cursor.row);
        highlightHit = (px > colCenter - hlHalf) && (px < colCenter + hlHalf) &&
                       (py > rowCenter - hlHalf) && (py < rowCenter + hlHalf);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            scanDly      <= '0;
            squarePix    <= 1'b0;
            highlightPix <= 1'b0;
        end else begin
            scanDly      <= scan;
            squarePix    <= squareHit;
            highlightPix <= highlightHit;
        end
        // which square, only meaningful with squarePix
        squareIdx <= {inY0, inX0};
    end

endmodule

// File: verilog/pixelColorMux.sv
// --------------------------------------------------
// pixel color select
// turns the square and highlight flags plus the mark
// bits into a 12-bit color and registers it with the
// matching scan position
// --------------------------------------------------
`timescale 1ns/1ps

module pixelColorMux (
    input  logic            clk,
    input  logic            reset,
    input  boardPkg::scanT   scanDly,
    input  logic            squarePix,
    input  logic            highlightPix,
    input  logic [1:0]      squareIdx,
    input  boardPkg::cursorT cursor,
    output boardPkg::pixelT  pixelOut
);
    import boardPkg::*;

    rgb12 colorSel;
    logic markHit;

    always_comb begin
        markHit = cursor.marks[squareIdx];
        // highest priority first
        if (!scanDly.active) begin
            colorSel = colorBg;
        end else if (highlightPix) begin
            colorSel = colorHighlight;
        end else if (squarePix && markHit) begin
            colorSel = colorMarked;
        end else if (squarePix) begin
            colorSel = colorSquare;
        end else begin
            colorSel = colorBg;
        end
    end

    // scan and color leave together, two cycles after scanTiming
    always_ff @(posedge clk) begin
        if (reset) begin
            pixelOut <= '0;
        end else begin
            pixelOut.scan  <= scanDly;
            pixelOut.color <= colorSel;
        end
    end

endmodule

// File: verilog/scanTiming.sv
// --------------------------------------------------
// raster scan timing
// walks x across each line and y down each frame,
// flags the visible 320x240 area and pulses the
// syncs at the counter wrap points
// --------------------------------------------------
`timescale 1ns/1ps

module scanTiming #(
    parameter int hTotal = 400,
    parameter int vTotal = 262
) (
    input  logic          clk,
    input  logic          reset,
    output boardPkg::scanT scan
);
    import boardPkg::*;

    // visible area limits
    localparam int activeW  = 320;
    localparam int activeH  = 240;
    // a frame has more lines than the 8-bit y field can hold
    localparam int lineBits = $clog2(vTotal);

    // x of scan is the pixel counter itself,
    // y of scan carries the low bits of the line counter
    logic [lineBits-1:0] lineCount;
    logic [lineBits-1:0] lineNext;
    xCoord               xNext;
    logic                lineWrap;
    logic                frameWrap;

    always_comb begin
        lineWrap  = (scan.x == xCoord'(hTotal - 1));
        frameWrap = (lineCount == lineBits'(vTotal - 1));
        // x wraps every line
        if (lineWrap) begin
            xNext = '0;
        end else begin
            xNext = scan.x + 9'd1;
        end
        // line only steps when x wraps
        if (!lineWrap) begin
            lineNext = lineCount;
        end else if (frameWrap) begin
            lineNext = '0;
        end else begin
            lineNext = lineCount + 1'b1;
        end
    end

    // every field comes from the next counter values,
    // so coordinates and flags stay on the same cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            scan      <= '0;
            lineCount <= '0;
        end else begin
            lineCount   <= lineNext;
            scan.x      <= xNext;
            scan.y      <= yCoord'(lineNext);
            scan.active <= (int'(xNext) < activeW) && (int'(lineNext) < activeH);
            scan.hsync  <= (xNext == '0);
            scan.vsync  <= (xNext == '0) && (lineNext == '0);
        end
    end

endmodule
